//--- include/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath widths
`define INSTRUCTION_WIDTH 32
`define XLEN 32

// Fetch starts here after reset
`define RESET_PC 32'h0

// Halfwords held by the align buffer
`define ALIGN_SLOTS 4

`endif

//--- logic/common.sv
`include "core_params.svh"

package common;

    typedef logic [`INSTRUCTION_WIDTH-1:0] insn_word_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LOAD  = 7'b0000011,
        OPC_STORE = 7'b0100011,
        OPC_IMM   = 7'b0010011,
        OPC_OP    = 7'b0110011,
        OPC_LUI   = 7'b0110111
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        insn_word_t word;
        r_fmt_t     r;
        i_fmt_t     i;
        s_fmt_t     s;
        u_fmt_t     u;
    } insn_formats_t;

    typedef struct packed {
        insn_word_t         window;   // Two oldest halfwords
        logic [`XLEN-1:0]   pc;
        logic [2:0]         count;    // Halfwords held
    } fetch_window_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        insn_word_t       instruction;
        logic             is_compressed;
        logic [6:0]       opcode;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [2:0]       funct3;
        logic [6:0]       funct7;
        logic [31:0]      imm;
    } decoded_t;

endpackage

//--- logic/compressed.sv
`timescale 1ns/100ps

module compressed import common::*; (
    input  insn_word_t mem_instruction,
    output logic       is_compressed,
    output insn_word_t instruction
);

logic [15:0] c;
logic [4:0]  rs1_p;    // rs1'/rd' field
logic [4:0]  rs2_p;    // rs2'/rd' field
logic [11:0] imm6_s;   // Sign extended 6-bit immediate
logic [11:0] shamt;
logic [11:0] mem_off;  // Word offset for C.LW and C.SW

assign c = mem_instruction[15:0];
assign rs1_p = {2'b01, c[9:7]};
assign rs2_p = {2'b01, c[4:2]};
assign imm6_s = {{6{c[12]}}, c[12], c[6:2]};
assign shamt = {6'b000000, c[12], c[6:2]};
assign mem_off = {5'b00000, c[5], c[12:10], c[6], 2'b00};

always_comb
begin
    is_compressed = 1'b1;
    instruction = {16'h0000, c};  // Unsupported forms stay zero-extended
    case (c[1:0])
        2'b00:
        begin
            if (c[15:13] == 3'b010)  // C.LW
                instruction = {mem_off, rs1_p, 3'b010, rs2_p, OPC_LOAD};
            else if (c[15:13] == 3'b110)  // C.SW
                instruction = {mem_off[11:5], rs2_p, rs1_p, 3'b010, mem_off[4:0], OPC_STORE};
        end
        2'b01:
        begin
            case (c[15:13])
                3'b000:  // C.ADDI
                    instruction = {imm6_s, c[11:7], 3'b000, c[11:7], OPC_IMM};
                3'b010:  // C.LI
                    instruction = {imm6_s, 5'b00000, 3'b000, c[11:7], OPC_IMM};
                3'b011:
                begin
                    // rd of x2 is C.ADDI16SP
                    if (c[11:7] != 5'd2)  // C.LUI
                        instruction = {{14{c[12]}}, c[12], c[6:2], c[11:7], OPC_LUI};
                end
                3'b100:
                begin
                    case (c[11:10])
                        2'b00:  // C.SRLI
                            instruction = {shamt, rs1_p, 3'b101, rs1_p, OPC_IMM};
                        2'b01:  // C.SRAI
                            instruction = {shamt | 12'h400, rs1_p, 3'b101, rs1_p, OPC_IMM};
                        2'b10:  // C.ANDI
                            instruction = {imm6_s, rs1_p, 3'b111, rs1_p, OPC_IMM};
                        default:
                        begin
                            if (!c[12])
                            begin
                                case (c[6:5])
                                    2'b00:  // C.SUB
                                        instruction = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p,
                                                       OPC_OP};
                                    2'b01:  // C.XOR
                                        instruction = {7'b0, rs2_p, rs1_p, 3'b100, rs1_p, OPC_OP};
                                    2'b10:  // C.OR
                                        instruction = {7'b0, rs2_p, rs1_p, 3'b110, rs1_p, OPC_OP};
                                    default:  // C.AND
                                        instruction = {7'b0, rs2_p, rs1_p, 3'b111, rs1_p, OPC_OP};
                                endcase
                            end
                        end
                    endcase
                end
                default:
                begin
                end
            endcase
        end
        2'b10:
        begin
            if (c[15:13] == 3'b000)  // C.SLLI
                instruction = {shamt, c[11:7], 3'b001, c[11:7], OPC_IMM};
            else if (c[15:13] == 3'b100 && c[6:2] != 5'd0)
            begin
                if (c[12])  // C.ADD
                    instruction = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], OPC_OP};
                else  // C.MV
                    instruction = {7'b0, c[6:2], 5'b00000, 3'b000, c[11:7], OPC_OP};
            end
        end
        default:
        begin
            is_compressed = 1'b0;
            instruction = mem_instruction;
        end
    endcase
end

endmodule

//--- logic/fetch_align.sv
`timescale 1ns/100ps
`include "core_params.svh"

module fetch_align import common::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic       flush,
    input  logic       drop_low,
    input  logic [1:0] consume_len,
    input  insn_word_t mem_rdata,
    output insn_word_t window,
    output logic [2:0] count
);

logic [15:0] slots      [`ALIGN_SLOTS];  // Slot 0 is the oldest
logic [15:0] next_slots [`ALIGN_SLOTS];
logic [2:0]  kept;
logic [2:0]  next_count;

always_comb
begin
    kept = count - {1'b0, consume_len};
    for (int i = 0; i < `ALIGN_SLOTS; i++)
    begin
        if (i + int'(consume_len) < `ALIGN_SLOTS)
            next_slots[i] = slots[i + int'(consume_len)];
        else
            next_slots[i] = slots[i];
        // New word lands right behind what is kept
        if (push && i == int'(kept))
            next_slots[i] = drop_low ? mem_rdata[31:16] : mem_rdata[15:0];
        if (push && !drop_low && i == int'(kept) + 1)
            next_slots[i] = mem_rdata[31:16];
    end
    next_count = kept + (!push ? 3'd0 : (drop_low ? 3'd1 : 3'd2));
end

always_ff @(posedge clk)
begin
    slots <= next_slots;
end

always_ff @(posedge clk)
begin
    if (rst || flush)
        count <= 3'd0;
    else
        count <= next_count;
end

assign window = {slots[1], slots[0]};

// Request throttling in the control keeps this bound
count_bounded: assert property (@(posedge clk) disable iff (rst)
    count <= 3'(`ALIGN_SLOTS));

endmodule

//--- logic/fetch_control.sv
`timescale 1ns/100ps
`include "core_params.svh"

module fetch_control (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    input  logic [2:0]       count,
    input  logic [1:0]       head_len,
    output logic             mem_req,
    output logic [`XLEN-1:0] mem_addr,
    output logic             push,
    output logic             flush,
    output logic             drop_low,
    output logic [1:0]       consume_len,
    output logic             issue,
    output logic [`XLEN-1:0] issue_pc
);

localparam logic [`XLEN-1:0] RESET_PC_W = `RESET_PC;

logic [`XLEN-1:0] fetch_pc;
logic             in_flight;
logic             flight_epoch;  // Epoch of the request now answering
logic             epoch;
logic             drop_pending;
logic             head_compressed;
logic             complete;
logic [1:0]       push_len;
logic [3:0]       occupancy;     // Buffer fill at the end of this cycle

assign head_compressed = head_len != 2'b11;
assign complete = (count != 3'd0 && head_compressed) || count >= 3'd2;
assign issue = complete && !stall && !redirect;
assign consume_len = !issue ? 2'd0 : (head_compressed ? 2'd1 : 2'd2);

// Stale responses die on the epoch compare
assign push = in_flight && flight_epoch == epoch && !redirect;
assign drop_low = push && drop_pending;
assign flush = redirect;
assign push_len = !push ? 2'd0 : (drop_low ? 2'd1 : 2'd2);

assign occupancy = {1'b0, count} - {2'b00, consume_len} + {2'b00, push_len};
assign mem_req = !rst && (occupancy + 4'd2 <= 4'(`ALIGN_SLOTS));
assign mem_addr = fetch_pc;

always_ff @(posedge clk)
begin
    if (rst)
    begin
        fetch_pc     <= {RESET_PC_W[`XLEN-1:2], 2'b00};
        issue_pc     <= RESET_PC_W;
        in_flight    <= 1'b0;
        flight_epoch <= 1'b0;
        epoch        <= 1'b0;
        drop_pending <= RESET_PC_W[1];
    end
    else
    begin
        in_flight    <= mem_req;
        flight_epoch <= epoch;
        if (redirect)
        begin
            epoch        <= ~epoch;
            fetch_pc     <= {redirect_pc[`XLEN-1:2], 2'b00};
            issue_pc     <= redirect_pc;
            drop_pending <= redirect_pc[1];  // Target in upper half of word
        end
        else
        begin
            if (mem_req)
                fetch_pc <= fetch_pc + `XLEN'd4;
            if (issue)
                issue_pc <= issue_pc + (head_compressed ? `XLEN'd2 : `XLEN'd4);
            if (push)
                drop_pending <= 1'b0;
        end
    end
end

// Downstream must hand over halfword aligned targets
redirect_aligned: assert property (@(posedge clk) disable iff (rst)
    redirect |-> !redirect_pc[0]);

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/100ps
`include "core_params.svh"

module fetch_unit import common::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    input  insn_word_t       mem_rdata,
    output logic             mem_req,
    output logic [`XLEN-1:0] mem_addr,
    output logic             out_valid,
    output decoded_t         out
);

logic             push;
logic             flush;
logic             drop_low;
logic             issue;
logic [1:0]       consume_len;
logic [`XLEN-1:0] issue_pc;
insn_word_t       align_window;
logic [2:0]       align_count;
fetch_window_t    head;         // Buffer head tagged with its pc
insn_word_t       expanded;
logic             is_compressed;

assign head = '{window: align_window, pc: issue_pc, count: align_count};

fetch_control u_control (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .count       (head.count),
    .head_len    (head.window[1:0]),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .push        (push),
    .flush       (flush),
    .drop_low    (drop_low),
    .consume_len (consume_len),
    .issue       (issue),
    .issue_pc    (issue_pc)
);

fetch_align u_align (
    .clk         (clk),
    .rst         (rst),
    .push        (push),
    .flush       (flush),
    .drop_low    (drop_low),
    .consume_len (consume_len),
    .mem_rdata   (mem_rdata),
    .window      (align_window),
    .count       (align_count)
);

compressed u_expand (
    .mem_instruction (head.window),
    .is_compressed   (is_compressed),
    .instruction     (expanded)
);

instruction_decode u_decode (
    .clk           (clk),
    .rst           (rst),
    .issue         (issue),
    .stall         (stall),
    .pc            (head.pc),
    .is_compressed (is_compressed),
    .instruction   (expanded),
    .out_valid     (out_valid),
    .out           (out)
);

endmodule

//--- logic/instruction_decode.sv
`timescale 1ns/100ps
`include "core_params.svh"

module instruction_decode import common::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue,
    input  logic             stall,
    input  logic [`XLEN-1:0] pc,
    input  logic             is_compressed,
    input  insn_word_t       instruction,
    output logic             out_valid,
    output decoded_t         out
);

insn_formats_t fmt;
decoded_t      next;

assign fmt = instruction;

always_comb
begin
    next.pc = pc;
    next.instruction = instruction;
    next.is_compressed = is_compressed;
    next.opcode = fmt.r.opcode;
    next.rd = fmt.r.rd;
    next.rs1 = fmt.r.rs1;
    next.rs2 = fmt.r.rs2;
    next.funct3 = fmt.r.funct3;
    next.funct7 = fmt.r.funct7;
    case (fmt.r.opcode)
        OPC_LOAD, OPC_IMM:  // Shift amounts sit in the I immediate too
            next.imm = {{20{fmt.i.imm[11]}}, fmt.i.imm};
        OPC_STORE:
            next.imm = {{20{fmt.s.imm_hi[6]}}, fmt.s.imm_hi, fmt.s.imm_lo};
        OPC_LUI:
            next.imm = {fmt.u.imm, 12'h000};
        default:
            next.imm = 32'h0;
    endcase
end

always_ff @(posedge clk)
begin
    if (rst)
        out_valid <= 1'b0;
    else if (issue)
        out_valid <= 1'b1;
    else if (!stall)
        out_valid <= 1'b0;  // Held while downstream stalls
end

always_ff @(posedge clk)
begin
    if (issue)
        out <= next;
end

valid_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(out_valid));

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -sv -f tb.f --top-module tb_fetch_unit -o sim_fetch_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_fetch_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0

//--- tb.f
+incdir+include
logic/common.sv
logic/fetch_control.sv
logic/fetch_align.sv
logic/compressed.sv
logic/instruction_decode.sv
logic/fetch_unit.sv
tests/tb_fetch_unit.sv

//--- tests/tb_fetch_unit.sv
`timescale 1ns/100ps
`include "core_params.svh"

module tb_fetch_unit import common::*; ();

localparam int NUM_OUTPUTS    = 1000;
localparam int TIMEOUT_CYCLES = 64;

logic             clk;
logic             rst;
logic             stall;
logic             redirect;
logic [`XLEN-1:0] redirect_pc;
insn_word_t       mem_rdata;
logic             mem_req;
logic [`XLEN-1:0] mem_addr;
logic             out_valid;
decoded_t         out;

insn_word_t       mem [0:63];
integer           seed = 32'hbabe;
logic             req_pending;      // Request seen in the previous cycle
logic [`XLEN-1:0] addr_pending;
logic [`XLEN-1:0] model_pc;         // Next pc the model expects
logic             held_valid;
decoded_t         held_out;
int               stall_left;
int               value_errors;
int               other_errors;
bit               timed_out;
int               outputs_seen;
int               waited;
bit               got;

fetch_unit DUT (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mem_rdata   (mem_rdata),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .out_valid   (out_valid),
    .out         (out)
);

initial
begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

task automatic put_half(input int idx, input logic [15:0] h);
    if (idx % 2 == 1)
        mem[idx / 2][31:16] = h;
    else
        mem[idx / 2][15:0] = h;
endtask

// Mixed stream whose first 21 instructions visit every kind once
task automatic fill_memory();
    int          hw;
    int          n_insn;
    int          kind;
    logic [31:0] r;
    logic [31:0] q;
    logic [15:0] h;
    logic [6:0]  opc;
    logic [4:0]  nz;
    hw = 0;
    n_insn = 0;
    while (hw < 128)
    begin
        r = $random(seed);
        q = $random(seed);
        kind = (n_insn < 21) ? n_insn : int'(r[31:24]) % 21;
        nz = (q[6:2] == 5'd0) ? 5'd1 : q[6:2];
        if (kind >= 15 && kind < 20 && hw < 127)
        begin
            case (kind)
                15: opc = 7'h03;
                16: opc = 7'h23;
                17: opc = 7'h13;
                18: opc = 7'h33;
                default: opc = 7'h37;
            endcase
            put_half(hw, {q[15:7], opc});
            put_half(hw + 1, q[31:16]);
            hw += 2;
        end
        else
        begin
            case (kind)
                0: h = {3'b010, q[12:2], 2'b00};                 // C.LW
                1: h = {3'b110, q[12:2], 2'b00};                 // C.SW
                2: h = {3'b000, q[12:2], 2'b10};                 // C.SLLI
                3: h = {4'b1001, q[11:7], nz, 2'b10};            // C.ADD
                4: h = {4'b1000, q[11:7], nz, 2'b10};            // C.MV
                5: h = {3'b000, q[12:2], 2'b01};                 // C.ADDI
                6: h = {3'b010, q[12:2], 2'b01};                 // C.LI
                7: h = {3'b011, q[12:8], 1'b1, q[6:2], 2'b01};   // C.LUI with odd rd
                8: h = {3'b100, q[12], 2'b00, q[9:2], 2'b01};    // C.SRLI
                9: h = {3'b100, q[12], 2'b01, q[9:2], 2'b01};    // C.SRAI
                10: h = {3'b100, q[12], 2'b10, q[9:2], 2'b01};   // C.ANDI
                11, 12, 13, 14: h = {6'b100011, q[9:7], 2'(kind - 11), q[4:2], 2'b01};
                default:
                    case (r[1:0])
                        2'd0: h = {3'b101, q[12:2], 2'b01};        // C.J
                        2'd1: h = {3'b000, q[12:2], 2'b00};        // C.ADDI4SPN
                        2'd2: h = {4'b1000, q[11:7], 5'd0, 2'b10}; // C.JR
                        default: h = {3'b110, q[12:2], 2'b10};     // C.SWSP
                    endcase
            endcase
            put_half(hw, h);
            hw++;
        end
        n_insn++;
    end
endtask

function automatic logic [15:0] half_at(input logic [31:0] pc);
    insn_word_t w;
    w = mem[pc[7:2]];
    return pc[1] ? w[31:16] : w[15:0];
endfunction

// RVC expansion of the supported subset
function automatic insn_word_t expand_model(input logic [15:0] h);
    logic [4:0]  rp;
    logic [4:0]  sp;
    logic [11:0] simm;
    logic [11:0] uimm;
    logic [11:0] off;
    insn_word_t  w;
    rp = {2'b01, h[9:7]};
    sp = {2'b01, h[4:2]};
    simm = 12'($signed({h[12], h[6:2]}));
    uimm = {6'd0, h[12], h[6:2]};
    off = {5'd0, h[5], h[12:10], h[6], 2'b00};
    w = {16'd0, h};
    case ({h[15:13], h[1:0]})
        5'b010_00: w = {off, rp, 3'b010, sp, 7'h03};
        5'b110_00: w = {off[11:5], sp, rp, 3'b010, off[4:0], 7'h23};
        5'b000_01: w = {simm, h[11:7], 3'b000, h[11:7], 7'h13};
        5'b010_01: w = {simm, 5'd0, 3'b000, h[11:7], 7'h13};
        5'b011_01:
            if (h[11:7] != 5'd2)
                w = {{8{simm[11]}}, simm, h[11:7], 7'h37};
        5'b100_01:
            case (h[11:10])
                2'b00: w = {uimm, rp, 3'b101, rp, 7'h13};
                2'b01: w = {6'b010000, uimm[5:0], rp, 3'b101, rp, 7'h13};
                2'b10: w = {simm, rp, 3'b111, rp, 7'h13};
                default:
                    if (!h[12])
                        case (h[6:5])
                            2'b00: w = {7'h20, sp, rp, 3'b000, rp, 7'h33};
                            2'b01: w = {7'h00, sp, rp, 3'b100, rp, 7'h33};
                            2'b10: w = {7'h00, sp, rp, 3'b110, rp, 7'h33};
                            default: w = {7'h00, sp, rp, 3'b111, rp, 7'h33};
                        endcase
            endcase
        5'b000_10: w = {uimm, h[11:7], 3'b001, h[11:7], 7'h13};
        5'b100_10:
            if (h[6:2] != 5'd0)
                w = {7'h00, h[6:2], h[12] ? h[11:7] : 5'd0, 3'b000, h[11:7], 7'h33};
        default: w = {16'd0, h};
    endcase
    return w;
endfunction

function automatic decoded_t model_at(input logic [31:0] pc);
    logic [15:0]   lo;
    insn_formats_t f;
    decoded_t      d;
    lo = half_at(pc);
    d.is_compressed = lo[1:0] != 2'b11;
    f.word = d.is_compressed ? expand_model(lo) : {half_at(pc + 32'd2), lo};
    d.pc = pc;
    d.instruction = f.word;
    d.opcode = f.r.opcode;
    d.rd = f.r.rd;
    d.rs1 = f.r.rs1;
    d.rs2 = f.r.rs2;
    d.funct3 = f.r.funct3;
    d.funct7 = f.r.funct7;
    case (f.r.opcode)
        7'h03, 7'h13: d.imm = 32'($signed(f.i.imm));
        7'h23: d.imm = 32'($signed({f.s.imm_hi, f.s.imm_lo}));
        7'h37: d.imm = {f.u.imm, 12'd0};
        default: d.imm = 32'd0;
    endcase
    return d;
endfunction

task automatic check_decoded(input decoded_t exp);
    if (out !== exp)
    begin
        value_errors++;
        $display("[FAIL] out: got %h, expected %h", out, exp);
    end
endtask

task automatic check_word(input insn_word_t exp);
    if (out.instruction !== exp)
    begin
        value_errors++;
        $display("[FAIL] out.instruction at pc %h: got %h, expected %h",
                 out.pc, out.instruction, exp);
    end
endtask

// One clock of stimulus, memory answer and output checks
task automatic step_cycle(output bit accepted);
    logic [31:0] r;
    logic [31:0] t;
    decoded_t    expected;
    @(negedge clk);
    mem_rdata = req_pending ? mem[addr_pending[7:2]] : insn_word_t'($random(seed));
    if (held_valid)
    begin
        if (!out_valid)
        begin
            value_errors++;
            $display("[FAIL] out_valid under stall: got %h, expected %h", out_valid, 1'b1);
        end
        check_decoded(held_out);
    end
    r = $random(seed);
    t = $random(seed);
    redirect = 1'b0;
    if (stall_left > 0)
    begin
        stall = 1'b1;
        stall_left--;
    end
    else if (r[4:0] == 5'd0)
    begin
        stall = 1'b1;
        stall_left = int'(r[7:5]);
    end
    else
        stall = 1'b0;
    if (!stall && r[12:8] == 5'd3)
    begin
        redirect = 1'b1;
        redirect_pc = {20'd0, t[11:1], 1'b0};
    end
    accepted = 1'b0;
    if (out_valid && !stall)
    begin
        expected = model_at(model_pc);
        check_decoded(expected);
        check_word(expected.instruction);
        model_pc = model_pc + (expected.is_compressed ? 32'd2 : 32'd4);
        accepted = 1'b1;
    end
    held_valid = out_valid && stall;
    held_out = out;
    if (redirect)
        model_pc = redirect_pc;  // Output shown this cycle was the last old one
    #1;
    if (mem_req && mem_addr[1:0] !== 2'b00)
    begin
        value_errors++;
        $display("[FAIL] mem_addr: got %h, expected %h",
                 mem_addr, {mem_addr[`XLEN-1:2], 2'b00});
    end
    req_pending = mem_req;
    addr_pending = mem_addr;
endtask

initial
begin
    rst = 1'b1;
    stall = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    mem_rdata = '0;
    held_valid = 1'b0;
    stall_left = 0;
    value_errors = 0;
    other_errors = 0;
    timed_out = 1'b0;
    model_pc = `RESET_PC;
    fill_memory();
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (mem_req || out_valid)
    begin
        other_errors++;
        $display("mem_req or out_valid was high during reset");
    end
    rst = 1'b0;
    #1;
    if (mem_req !== 1'b1)
    begin
        value_errors++;
        $display("[FAIL] mem_req after reset: got %h, expected %h", mem_req, 1'b1);
    end
    req_pending = mem_req;
    addr_pending = mem_addr;
    outputs_seen = 0;
    while (outputs_seen < NUM_OUTPUTS && !timed_out)
    begin
        waited = 0;
        got = 1'b0;
        while (!got && waited < TIMEOUT_CYCLES)
        begin
            step_cycle(got);
            waited++;
        end
        if (!got)
        begin
            timed_out = 1'b1;
            $display("No instruction came out within %0d cycles, expected pc %h",
                     TIMEOUT_CYCLES, model_pc);
        end
        outputs_seen++;
    end
    $display("Errors: %0d wrong values, %0d other, %0d timeouts",
             value_errors, other_errors, timed_out);
    if (value_errors == 0 && other_errors == 0 && !timed_out)
        $display("Test passed");
    else
        $display("Test failed");
    $finish;
end

endmodule
